// File: verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;

    localparam addr_t inst_bytes = 32'd4;

    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_copy2
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump
    } br_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_req,
        mem_wait
    } mem_state_e;

    typedef struct packed {
        alu_op_e   alu_op;
        br_e       br;
        logic      use_imm;
        logic      mem_read;
        logic      mem_write;
        logic      rf_wen;
        wb_sel_e   wb_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } dreq_t;

    // pending register write of a later stage
    typedef struct packed {
        logic      valid;
        logic      can_forward;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        addr_t pc;
        ctrl_t ctrl;
        word_t imm;
    } ds_t;

    typedef struct packed {
        addr_t pc;
        ctrl_t ctrl;
        word_t imm;
        word_t rs1_data;
        word_t rs2_data;
    } exe_t;

    typedef struct packed {
        addr_t pc;
        ctrl_t ctrl;
        word_t result;
        word_t rs2_data;
    } mem_t;

    typedef struct packed {
        addr_t pc;
        ctrl_t ctrl;
        word_t result;
        word_t rdata;
    } wb_t;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  rv_pipe_pkg::inst_t inst_i,
    output rv_pipe_pkg::ctrl_t ctrl_o,
    output rv_pipe_pkg::word_t imm_o
);
    import rv_pipe_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // unused source fields stay at x0 so they never raise a hazard
    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (opcode)
            op_reg: begin
                ctrl_o.rs1    = inst_i[19:15];
                ctrl_o.rs2    = inst_i[24:20];
                ctrl_o.rd     = inst_i[11:7];
                ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl_o.alu_op = alu_add;
                    10'b0100000_000: ctrl_o.alu_op = alu_sub;
                    10'b0000000_111: ctrl_o.alu_op = alu_and;
                    10'b0000000_110: ctrl_o.alu_op = alu_or;
                    10'b0000000_100: ctrl_o.alu_op = alu_xor;
                    10'b0000000_010: ctrl_o.alu_op = alu_slt;
                    default: ctrl_o = '0;
                endcase
            end
            op_imm: begin
                if (funct3 == 3'b000) begin
                    ctrl_o.rs1     = inst_i[19:15];
                    ctrl_o.rd      = inst_i[11:7];
                    ctrl_o.use_imm = 1'b1;
                    ctrl_o.rf_wen  = 1'b1;
                    imm_o          = imm_i;
                end
            end
            op_lui: begin
                ctrl_o.rd      = inst_i[11:7];
                ctrl_o.alu_op  = alu_copy2;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.rf_wen  = 1'b1;
                imm_o          = imm_u;
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.rs1      = inst_i[19:15];
                    ctrl_o.rd       = inst_i[11:7];
                    ctrl_o.use_imm  = 1'b1;
                    ctrl_o.mem_read = 1'b1;
                    ctrl_o.rf_wen   = 1'b1;
                    ctrl_o.wb_sel   = wb_mem;
                    imm_o           = imm_i;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.rs1       = inst_i[19:15];
                    ctrl_o.rs2       = inst_i[24:20];
                    ctrl_o.use_imm   = 1'b1;
                    ctrl_o.mem_write = 1'b1;
                    imm_o            = imm_s;
                end
            end
            op_branch: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl_o.rs1 = inst_i[19:15];
                    ctrl_o.rs2 = inst_i[24:20];
                    ctrl_o.br  = funct3[0] ? br_ne : br_eq;
                    imm_o      = imm_b;
                end
            end
            op_jal: begin
                ctrl_o.rd     = inst_i[11:7];
                ctrl_o.br     = br_jump;
                ctrl_o.rf_wen = 1'b1;
                ctrl_o.wb_sel = wb_pc4;
                imm_o         = imm_j;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/data_select_stage.sv
`timescale 1ns/1ps

module data_select_stage (
    input  rv_pipe_pkg::ctrl_t ctrl_i,
    input  rv_pipe_pkg::word_t rf_rs1_data_i,
    input  rv_pipe_pkg::word_t rf_rs2_data_i,
    input  rv_pipe_pkg::fwd_t  exe_fwd_i,
    input  rv_pipe_pkg::fwd_t  mem_fwd_i,
    input  rv_pipe_pkg::fwd_t  wb_fwd_i,
    output rv_pipe_pkg::word_t rs1_data_o,
    output rv_pipe_pkg::word_t rs2_data_o,
    output logic               hazard_stall_o
);
    import rv_pipe_pkg::*;

    logic rs1_stall;
    logic rs2_stall;

    function automatic word_t forward(
        input  reg_addr_t rs,
        input  word_t     rf_data,
        input  fwd_t      exe_fwd,
        input  fwd_t      mem_fwd,
        input  fwd_t      wb_fwd,
        output logic      stall
    );
        fwd_t  writers [3];
        word_t data;
        writers = '{exe_fwd, mem_fwd, wb_fwd};
        data    = rf_data;
        stall   = 1'b0;
        // walk oldest to youngest so the youngest match wins
        for (int i = 2; i >= 0; i--) begin
            if (writers[i].valid && writers[i].rd == rs && rs != '0) begin
                data  = writers[i].data;
                stall = !writers[i].can_forward;
            end
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = forward(ctrl_i.rs1, rf_rs1_data_i, exe_fwd_i, mem_fwd_i, wb_fwd_i,
                             rs1_stall);
        rs2_data_o = forward(ctrl_i.rs2, rf_rs2_data_i, exe_fwd_i, mem_fwd_i, wb_fwd_i,
                             rs2_stall);
    end

    assign hazard_stall_o = rs1_stall || rs2_stall;

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  rv_pipe_pkg::addr_t pc_i,
    input  rv_pipe_pkg::ctrl_t ctrl_i,
    input  rv_pipe_pkg::word_t imm_i,
    input  rv_pipe_pkg::word_t rs1_data_i,
    input  rv_pipe_pkg::word_t rs2_data_i,
    output rv_pipe_pkg::word_t result_o,
    output logic               taken_o,
    output rv_pipe_pkg::addr_t target_o
);
    import rv_pipe_pkg::*;

    word_t op2;
    logic  lt;

    assign op2 = ctrl_i.use_imm ? imm_i : rs2_data_i;
    assign lt  = $signed(rs1_data_i) < $signed(op2);

    // loads and stores come through as add
    always_comb begin
        case (ctrl_i.alu_op)
            alu_sub:   result_o = rs1_data_i - op2;
            alu_and:   result_o = rs1_data_i & op2;
            alu_or:    result_o = rs1_data_i | op2;
            alu_xor:   result_o = rs1_data_i ^ op2;
            alu_slt:   result_o = {{(xlen-1){1'b0}}, lt};
            alu_copy2: result_o = op2;
            default:   result_o = rs1_data_i + op2;
        endcase
    end

    always_comb begin
        case (ctrl_i.br)
            br_eq:   taken_o = rs1_data_i == rs2_data_i;
            br_ne:   taken_o = rs1_data_i != rs2_data_i;
            br_jump: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    assign target_o = pc_i + imm_i;

endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  rv_pipe_pkg::ctrl_t ctrl_i,
    input  rv_pipe_pkg::addr_t addr_i,
    input  rv_pipe_pkg::word_t wdata_i,
    output logic               dreq_valid_o,
    output rv_pipe_pkg::dreq_t dreq_o,
    input  logic               dreq_ready_i,
    input  logic               dresp_valid_i,
    input  rv_pipe_pkg::word_t dresp_rdata_i,
    output rv_pipe_pkg::word_t rdata_o,
    output logic               busy_o
);
    import rv_pipe_pkg::*;

    mem_state_e state;
    mem_state_e state_d;
    logic       is_mem;

    assign is_mem = valid_i && (ctrl_i.mem_read || ctrl_i.mem_write);

    always_comb begin
        state_d = state;
        case (state)
            mem_idle: begin
                if (is_mem) state_d = dreq_ready_i ? mem_wait : mem_req;
            end
            mem_req: begin
                if (dreq_ready_i) state_d = mem_wait;
            end
            mem_wait: begin
                if (dresp_valid_i) state_d = mem_idle;
            end
            default: state_d = mem_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= mem_idle;
        end else begin
            state <= state_d;
        end
    end

    // the stage register holds while busy, so the request stays stable
    assign dreq_valid_o = (state == mem_idle && is_mem) || state == mem_req;
    assign dreq_o       = '{addr: addr_i, wdata: wdata_i, write: ctrl_i.mem_write};

    assign busy_o  = is_mem && !(state == mem_wait && dresp_valid_i);
    assign rdata_o = dresp_rdata_i;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   wb_valid_i,
    input  rv_pipe_pkg::ctrl_t     ctrl_i,
    input  rv_pipe_pkg::word_t     alu_i,
    input  rv_pipe_pkg::word_t     mem_rdata_i,
    input  rv_pipe_pkg::addr_t     pc_i,
    input  rv_pipe_pkg::reg_addr_t rs1_i,
    input  rv_pipe_pkg::reg_addr_t rs2_i,
    output rv_pipe_pkg::word_t     rs1_data_o,
    output rv_pipe_pkg::word_t     rs2_data_o,
    output rv_pipe_pkg::fwd_t      wb_fwd_o
);
    import rv_pipe_pkg::*;

    word_t regs [32];
    word_t wdata;
    logic  wen;

    always_comb begin
        case (ctrl_i.wb_sel)
            wb_mem:  wdata = mem_rdata_i;
            wb_pc4:  wdata = pc_i + inst_bytes;
            default: wdata = alu_i;
        endcase
    end

    // x0 is never written
    assign wen = wb_valid_i && ctrl_i.rf_wen && ctrl_i.rd != '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[ctrl_i.rd] <= wdata;
        end
    end

    // write-through on a same-cycle write
    assign rs1_data_o = (wen && ctrl_i.rd == rs1_i) ? wdata : regs[rs1_i];
    assign rs2_data_o = (wen && ctrl_i.rd == rs2_i) ? wdata : regs[rs2_i];

    assign wb_fwd_o = '{valid: wb_valid_i && ctrl_i.rf_wen, can_forward: 1'b1,
                        rd: ctrl_i.rd, data: wdata};

endmodule

// File: verilog/rv_pipe.sv
`timescale 1ns/1ps

module rv_pipe (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                fetch_valid_i,
    input  rv_pipe_pkg::fetch_t fetch_i,
    output logic                fetch_ready_o,
    output logic                redirect_valid_o,
    output rv_pipe_pkg::addr_t  redirect_pc_o,
    output logic                dreq_valid_o,
    output rv_pipe_pkg::dreq_t  dreq_o,
    input  logic                dreq_ready_i,
    input  logic                dresp_valid_i,
    input  rv_pipe_pkg::word_t  dresp_rdata_i
);
    import rv_pipe_pkg::*;

    logic   id_valid;
    fetch_t id_q;
    ctrl_t  id_ctrl;
    word_t  id_imm;

    logic   ds_valid;
    ds_t    ds_q;
    word_t  rf_rs1_data;
    word_t  rf_rs2_data;
    word_t  ds_rs1_data;
    word_t  ds_rs2_data;
    logic   ds_hazard;

    logic   exe_valid;
    exe_t   exe_q;
    word_t  exe_result;
    logic   exe_taken;
    addr_t  exe_target;

    logic   mem_valid;
    mem_t   mem_q;
    word_t  mem_rdata;
    logic   mem_busy;

    logic   wb_valid;
    wb_t    wb_q;

    fwd_t   exe_fwd;
    fwd_t   mem_fwd;
    fwd_t   wb_fwd;

    logic   mem_stall;
    logic   exe_stall;
    logic   ds_stall;
    logic   id_stall;
    logic   flush;

    assign mem_stall     = mem_valid && mem_busy;
    assign exe_stall     = exe_valid && mem_stall;
    assign ds_stall      = ds_valid && (exe_stall || ds_hazard);
    assign id_stall      = id_valid && ds_stall;
    assign fetch_ready_o = !id_stall;

    // taken only on the edge the branch leaves execute, so it redirects once
    assign flush = exe_valid && exe_taken && !exe_stall;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) redirect_pc_o <= exe_target;
    end

    // fetch offers during the pulse are stale
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid <= 1'b0;
        end else if (flush || redirect_valid_o) begin
            id_valid <= 1'b0;
        end else if (!id_stall) begin
            id_valid <= fetch_valid_i;
            id_q     <= fetch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (!ds_stall) begin
            ds_valid <= id_valid;
            ds_q     <= '{pc: id_q.pc, ctrl: id_ctrl, imm: id_imm};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exe_valid <= 1'b0;
        end else if (!exe_stall) begin
            exe_valid <= ds_valid && !ds_stall && !flush;
            exe_q     <= '{pc: ds_q.pc, ctrl: ds_q.ctrl, imm: ds_q.imm,
                           rs1_data: ds_rs1_data, rs2_data: ds_rs2_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_valid <= 1'b0;
        end else if (!mem_stall) begin
            mem_valid <= exe_valid;
            mem_q     <= '{pc: exe_q.pc, ctrl: exe_q.ctrl, result: exe_result,
                           rs2_data: exe_q.rs2_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid && !mem_stall;
            wb_q     <= '{pc: mem_q.pc, ctrl: mem_q.ctrl, result: mem_q.result,
                          rdata: mem_rdata};
        end
    end

    // memory forwards anything but a load and execute never forwards
    assign exe_fwd = '{valid: exe_valid && exe_q.ctrl.rf_wen, can_forward: 1'b0,
                       rd: exe_q.ctrl.rd, data: '0};
    assign mem_fwd = '{valid: mem_valid && mem_q.ctrl.rf_wen,
                       can_forward: mem_q.ctrl.wb_sel != wb_mem,
                       rd: mem_q.ctrl.rd,
                       data: (mem_q.ctrl.wb_sel == wb_pc4) ? mem_q.pc + inst_bytes
                                                           : mem_q.result};

    decode_stage u_decode (
        .inst_i (id_q.inst),
        .ctrl_o (id_ctrl),
        .imm_o  (id_imm)
    );

    data_select_stage u_data_select (
        .ctrl_i         (ds_q.ctrl),
        .rf_rs1_data_i  (rf_rs1_data),
        .rf_rs2_data_i  (rf_rs2_data),
        .exe_fwd_i      (exe_fwd),
        .mem_fwd_i      (mem_fwd),
        .wb_fwd_i       (wb_fwd),
        .rs1_data_o     (ds_rs1_data),
        .rs2_data_o     (ds_rs2_data),
        .hazard_stall_o (ds_hazard)
    );

    execute_stage u_execute (
        .pc_i       (exe_q.pc),
        .ctrl_i     (exe_q.ctrl),
        .imm_i      (exe_q.imm),
        .rs1_data_i (exe_q.rs1_data),
        .rs2_data_i (exe_q.rs2_data),
        .result_o   (exe_result),
        .taken_o    (exe_taken),
        .target_o   (exe_target)
    );

    memory_stage u_memory (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (mem_valid),
        .ctrl_i        (mem_q.ctrl),
        .addr_i        (mem_q.result),
        .wdata_i       (mem_q.rs2_data),
        .dreq_valid_o  (dreq_valid_o),
        .dreq_o        (dreq_o),
        .dreq_ready_i  (dreq_ready_i),
        .dresp_valid_i (dresp_valid_i),
        .dresp_rdata_i (dresp_rdata_i),
        .rdata_o       (mem_rdata),
        .busy_o        (mem_busy)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_valid_i  (wb_valid),
        .ctrl_i      (wb_q.ctrl),
        .alu_i       (wb_q.result),
        .mem_rdata_i (wb_q.rdata),
        .pc_i        (wb_q.pc),
        .rs1_i       (ds_q.ctrl.rs1),
        .rs2_i       (ds_q.ctrl.rs2),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data),
        .wb_fwd_o    (wb_fwd)
    );

endmodule

// File: tb/rv_pipe_chk.sv
`timescale 1ns/1ps

module rv_pipe_chk (
    input logic               clk,
    input logic               rst_n_i,
    input logic               redirect_valid_i,
    input logic               dreq_valid_i,
    input rv_pipe_pkg::dreq_t dreq_i,
    input logic               dreq_ready_i
);
    import rv_pipe_pkg::*;

    // a stalled request must not change
    assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq_valid_i && !dreq_ready_i |=> dreq_valid_i && $stable(dreq_i))
        else $error("data request changed while waiting for ready");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_i |=> !redirect_valid_i)
        else $error("redirect pulse longer than one cycle");

    assert property (@(posedge clk)
        !rst_n_i && $past(!rst_n_i) |-> !redirect_valid_i && !dreq_valid_i)
        else $error("control output high during reset");

endmodule

// File: tb/rv_pipe_tb_mem.sv
`timescale 1ns/1ps

module rv_pipe_tb_mem (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                backpressure_i,
    output logic                fetch_valid_o,
    output rv_pipe_pkg::fetch_t fetch_o,
    input  logic                fetch_ready_i,
    input  logic                redirect_valid_i,
    input  rv_pipe_pkg::addr_t  redirect_pc_i,
    input  logic                dreq_valid_i,
    input  rv_pipe_pkg::dreq_t  dreq_i,
    output logic                dreq_ready_o,
    output logic                dresp_valid_o,
    output rv_pipe_pkg::word_t  dresp_rdata_o
);
    import rv_pipe_pkg::*;

    inst_t       imem [64];
    word_t       dmem [256];
    addr_t       st_addr [32];
    word_t       st_data [32];
    int          st_count;
    addr_t       pc;
    logic        pending;
    int unsigned delay;

    assign fetch_o = '{pc: pc, inst: imem[pc[7:2]]};

    initial begin
        fetch_valid_o = 1'b0;
        dreq_ready_o  = 1'b0;
        dresp_valid_o = 1'b0;
        dresp_rdata_o = '0;
        pc            = '0;
        pending       = 1'b0;
        delay         = 0;
        st_count      = 0;
    end

    always @(posedge clk) begin
        dresp_valid_o <= 1'b0;
        if (!rst_n_i) begin
            fetch_valid_o <= 1'b0;
            pc            <= '0;
            pending       <= 1'b0;
            dreq_ready_o  <= 1'b1;
            st_count      <= 0;
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'h5a00_0000 | (i * 4);
            end
        end else begin
            fetch_valid_o <= 1'b1;
            // redirect wins over the sequential step
            if (redirect_valid_i) begin
                pc <= redirect_pc_i;
            end else if (fetch_valid_o && fetch_ready_i) begin
                pc <= pc + inst_bytes;
            end
            dreq_ready_o <= backpressure_i ? 1'($urandom_range(1, 0)) : 1'b1;
            if (dreq_valid_i && dreq_ready_o) begin
                pending <= 1'b1;
                delay   <= backpressure_i ? $urandom_range(3, 0) : 0;
                if (dreq_i.write) begin
                    dmem[dreq_i.addr[9:2]] <= dreq_i.wdata;
                    st_addr[st_count]      <= dreq_i.addr;
                    st_data[st_count]      <= dreq_i.wdata;
                    st_count               <= st_count + 1;
                    dresp_rdata_o          <= '0;
                end else begin
                    dresp_rdata_o <= dmem[dreq_i.addr[9:2]];
                end
            end else if (pending) begin
                if (delay == 0) begin
                    dresp_valid_o <= 1'b1;
                    pending       <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

// File: tb/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int max_prog_len   = 17;
    localparam int test_count     = 5;
    localparam int timeout_cycles = 40 * max_prog_len * test_count;
    localparam int settle_cycles  = 20;

    logic   clk;
    logic   rst_n_i;
    logic   backpressure;
    logic   fetch_valid;
    fetch_t fetch;
    logic   fetch_ready;
    logic   redirect_valid;
    addr_t  redirect_pc;
    logic   dreq_valid;
    dreq_t  dreq;
    logic   dreq_ready;
    logic   dresp_valid;
    word_t  dresp_rdata;

    int     cycle_count = 0;
    int     error_count;
    int     failed_tests;
    inst_t  prog [$];
    addr_t  exp_addr [$];
    word_t  exp_data [$];

    rv_pipe uut (
        .clk(clk), .rst_n_i(rst_n_i),
        .fetch_valid_i(fetch_valid), .fetch_i(fetch), .fetch_ready_o(fetch_ready),
        .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc),
        .dreq_valid_o(dreq_valid), .dreq_o(dreq), .dreq_ready_i(dreq_ready),
        .dresp_valid_i(dresp_valid), .dresp_rdata_i(dresp_rdata)
    );

    rv_pipe_tb_mem u_mem (
        .clk(clk), .rst_n_i(rst_n_i), .backpressure_i(backpressure),
        .fetch_valid_o(fetch_valid), .fetch_o(fetch), .fetch_ready_i(fetch_ready),
        .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
        .dreq_valid_i(dreq_valid), .dreq_i(dreq), .dreq_ready_o(dreq_ready),
        .dresp_valid_o(dresp_valid), .dresp_rdata_o(dresp_rdata)
    );

    bind rv_pipe rv_pipe_chk u_chk (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_valid_i(redirect_valid_o),
        .dreq_valid_i(dreq_valid_o), .dreq_i(dreq_o), .dreq_ready_i(dreq_ready_i)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: stores did not complete within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic inst_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_imm};
    endfunction

    function automatic inst_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, op_load};
    endfunction

    function automatic inst_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic inst_t branch_word(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic inst_t jal_word(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic inst_t lui_word(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_store(input addr_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // reset, load the program, run to the last store and compare the log
    task automatic run_program(input string name);
        int errs_before;
        errs_before = error_count;
        @(posedge clk);
        rst_n_i <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            u_mem.imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        while (u_mem.st_count < exp_addr.size()) @(negedge clk);
        repeat (settle_cycles) @(negedge clk);
        if (u_mem.st_count != exp_addr.size()) begin
            $display("%s: %0d stores seen where %0d were expected",
                     name, u_mem.st_count, exp_addr.size());
            error_count++;
        end
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_addr($sformatf("store_addr[%0d]", i), u_mem.st_addr[i], exp_addr[i]);
            check_word($sformatf("store_data[%0d]", i), u_mem.st_data[i], exp_data[i]);
        end
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            failed_tests++;
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic test_alu();
        word_t a;
        word_t b;
        a = 32'd100;
        b = -32'sd7;
        prog = '{addi_word(1, 0, 12'd100), addi_word(2, 0, -12'sd7),
                 r_word(7'h00, 3'b000, 3, 1, 2), r_word(7'h20, 3'b000, 4, 1, 2),
                 r_word(7'h00, 3'b111, 5, 1, 2), r_word(7'h00, 3'b110, 6, 1, 2),
                 r_word(7'h00, 3'b100, 7, 1, 2), r_word(7'h00, 3'b010, 8, 2, 1),
                 lui_word(9, 20'h12345)};
        for (int r = 3; r <= 9; r++) begin
            prog.push_back(store_word(r, 0, 12'((r - 3) * 4)));
        end
        prog.push_back(jal_word(0, '0));
        expect_store(32'd0, a + b);
        expect_store(32'd4, a - b);
        expect_store(32'd8, a & b);
        expect_store(32'd12, a | b);
        expect_store(32'd16, a ^ b);
        expect_store(32'd20, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(32'd24, 32'h12345 << 12);
        run_program("alu");
    endtask

    // dependent chain with a load followed by its use
    task automatic build_forwarding();
        prog = '{addi_word(1, 0, 12'd5), addi_word(2, 1, 12'd3),
                 r_word(7'h00, 3'b000, 3, 2, 1), store_word(3, 0, 12'd0),
                 load_word(4, 0, 12'd0), r_word(7'h00, 3'b000, 5, 4, 2),
                 store_word(5, 0, 12'd4), r_word(7'h20, 3'b000, 6, 5, 3),
                 store_word(6, 0, 12'd8), jal_word(0, '0)};
        expect_store(32'd0, 32'd5 + 32'd3 + 32'd5);
        expect_store(32'd4, 32'd13 + 32'd8);
        expect_store(32'd8, 32'd21 - 32'd13);
    endtask

    task automatic test_forwarding();
        build_forwarding();
        run_program("forwarding");
    endtask

    task automatic test_branches();
        prog = '{addi_word(1, 0, 12'd1), addi_word(2, 0, 12'd1),
                 branch_word(3'b000, 1, 2, 13'd8), store_word(1, 0, 12'd64),
                 branch_word(3'b001, 1, 2, 13'd8), addi_word(3, 0, 12'd33),
                 branch_word(3'b000, 1, 0, 13'd8), store_word(3, 0, 12'd0),
                 branch_word(3'b001, 1, 0, 13'd8), store_word(1, 0, 12'd68),
                 jal_word(5, 21'd8), store_word(1, 0, 12'd72),
                 store_word(5, 0, 12'd4), jal_word(0, '0)};
        expect_store(32'd0, 32'd33);
        // jal sits at pc 40
        expect_store(32'd4, 32'd40 + 32'd4);
        run_program("branches");
    endtask

    task automatic test_load_store();
        prog = '{addi_word(1, 0, 12'h055), lui_word(2, 20'habcde),
                 r_word(7'h00, 3'b000, 3, 2, 1), store_word(3, 0, 12'd32),
                 addi_word(4, 0, 12'd0), load_word(5, 0, 12'd32),
                 store_word(5, 0, 12'd36), jal_word(0, '0)};
        expect_store(32'd32, (32'habcde << 12) + 32'h55);
        expect_store(32'd36, (32'habcde << 12) + 32'h55);
        run_program("load_store");
    endtask

    task automatic test_backpressure();
        build_forwarding();
        @(posedge clk);
        backpressure <= 1'b1;
        run_program("backpressure");
        @(posedge clk);
        backpressure <= 1'b0;
    endtask

    initial begin
        rst_n_i      = 1'b0;
        backpressure = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        void'($urandom(51888));
        test_alu();
        test_forwarding();
        test_branches();
        test_load_store();
        test_backpressure();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: rv_pipe.f
verilog/rv_pipe_pkg.sv
verilog/decode_stage.sv
verilog/data_select_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/reg_file.sv
verilog/rv_pipe.sv
tb/rv_pipe_chk.sv
tb/rv_pipe_tb_mem.sv
tb/rv_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_pipe_tb
FILELIST  ?= rv_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
